// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP       := tb_rv32_exec
RTL_TOP   := rv32_exec_top
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
design/rv32_isa_pkg.sv
design/exec_pkg.sv
design/approx_adder.sv
design/arithmetic_logic_unit.sv
design/decode_stage.sv
design/rv32_exec_top.sv
verif/rv32_exec_assertions.sv
verif/tb_rv32_exec.sv

// ==== design/approx_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module approx_adder
    import rv32_isa_pkg::*;
(
    input  wire logic [xlen-1:0] a,
    input  wire logic [xlen-1:0] b,
    input  wire logic [5:0]      approx_bits,          // Lower part width L
    input  wire logic            approx_en,            // Low gives a plain adder
    output logic      [xlen-1:0] sum
);

    logic [5:0]      lower_len;                        // Effective L
    logic [xlen:0]   lower_mask_wide;                  // One bit extra for L = 32
    logic [xlen-1:0] lower_mask;                       // Ones over bits L-1..0
    logic [xlen-1:0] top_bit;                          // One hot at bit L-1
    logic            carry_in;                         // Into bit L
    logic [xlen-1:0] carry_vec;                        // Carry placed at bit L
    logic [xlen-1:0] upper_sum;

    assign lower_len = approx_en ? approx_bits : 6'd0;

    // ----------------------------------------
    // Lower part, OR of operands
    // ----------------------------------------
    assign lower_mask_wide = ({{xlen{1'b0}}, 1'b1} << lower_len) - 1'b1;
    assign lower_mask      = lower_mask_wide[xlen-1:0];
    assign top_bit         = lower_mask ^ (lower_mask >> 1); // Zero when L = 0

    // Carry guessed from the top lower-part bits
    assign carry_in  = |(a & b & top_bit);
    assign carry_vec = {top_bit[xlen-2:0], 1'b0} & {xlen{carry_in}}; // Lost when L = 32

    // ----------------------------------------
    // Upper part, exact sum
    // ----------------------------------------
    assign upper_sum = (a & ~lower_mask) + (b & ~lower_mask) + carry_vec;

    assign sum = ((a | b) & lower_mask) | (upper_sum & ~lower_mask);

endmodule

`default_nettype wire

// ==== design/arithmetic_logic_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module arithmetic_logic_unit
    import rv32_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        dec_valid,                // From decode register
    input  wire decoded_op_t dec_op,
    output logic             result_valid,
    output exec_result_t     result
);

    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [4:0]      shamt;                            // Low 5 bits of B
    logic [xlen-1:0] adder_a;
    logic [xlen-1:0] adder_b;
    logic [5:0]      adder_approx_bits;                // Approximate width L
    logic            adder_approx_en;
    logic [xlen-1:0] adder_sum;
    logic [xlen-1:0] alu_value;
    exec_result_t    result_next;

    // ----------------------------------------
    // Operand multiplexers
    // ----------------------------------------
    always_comb
    begin
        case (dec_op.opa_sel)
            opa_pc:  operand_a = dec_op.pc;            // JAL, JALR, AUIPC
            default: operand_a = dec_op.rs1_value;
        endcase
        case (dec_op.opb_sel)
            opb_imm:  operand_b = dec_op.imm;
            opb_four: operand_b = 32'd4;               // Link address offset
            default:  operand_b = dec_op.rs2_value;
        endcase
    end

    assign shamt = operand_b[4:0];

    // ----------------------------------------
    // Shared adder
    // ----------------------------------------
    assign adder_a = operand_a;
    assign adder_b = (dec_op.op == alu_sub) ? (~operand_b + 32'd1) : operand_b; // Two's complement

    // L = 32 - accuracy, nothing approximate from 32 up
    assign adder_approx_bits = (dec_op.accuracy >= 8'd32) ? 6'd0
                                                          : 6'(8'd32 - dec_op.accuracy);
    assign adder_approx_en   = dec_op.use_approx;      // Never set for link or AUIPC

    approx_adder u_adder (
        .a           (adder_a),
        .b           (adder_b),
        .approx_bits (adder_approx_bits),
        .approx_en   (adder_approx_en),
        .sum         (adder_sum)
    );

    // ----------------------------------------
    // Operation select
    // ----------------------------------------
    always_comb
    begin
        case (dec_op.op)
            alu_add,
            alu_sub,
            alu_link: alu_value = adder_sum;           // All sums via the adder
            alu_sll:  alu_value = operand_a << shamt;
            alu_slt:  alu_value = {31'b0, $signed(operand_a) < $signed(operand_b)};
            alu_sltu: alu_value = {31'b0, operand_a < operand_b};
            alu_xor:  alu_value = operand_a ^ operand_b;
            alu_srl:  alu_value = operand_a >> shamt;
            alu_sra:  alu_value = $unsigned($signed(operand_a) >>> shamt); // Sign fill
            alu_or:   alu_value = operand_a | operand_b;
            alu_and:  alu_value = operand_a & operand_b;
            default:  alu_value = '0;                  // Illegal word
        endcase
    end

    always_comb
    begin
        result_next.rd      = dec_op.rd;
        result_next.illegal = (dec_op.op == alu_illegal);
        result_next.value   = result_next.illegal ? '0 : alu_value;
    end

    // ----------------------------------------
    // Result register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result_valid <= 1'b0;
            result       <= '0;                        // All zeros out of reset
        end
        else
        begin
            result_valid <= dec_valid;
            if (dec_valid)
                result <= result_next;                 // Hold last result otherwise
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv32_isa_pkg::*;
    import exec_pkg::*;
#(
    parameter bit         APPROX_ENABLE  = 1'b1,      // Allow approximate adds
    parameter logic [7:0] RESET_ACCURACY = 8'd32      // Exact after reset
)
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            inst_valid,           // One strobe per word
    input  wire logic [31:0]     inst,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] rs1_data,
    input  wire logic [xlen-1:0] rs2_data,
    output logic                 dec_valid,
    output decoded_op_t          dec_op
);

    // Instruction fields
    opcode_e           opcode;
    funct3_e           funct3;
    logic [6:0]        funct7;
    logic [xlen-1:0]   imm_i;
    logic [xlen-1:0]   imm_u;
    logic [xlen-1:0]   imm_j;
    logic              is_csr_write;                   // CSRRW to accuracy CSR
    logic [7:0]        accuracy;                       // Accuracy CSR
    decoded_op_t       dec_next;

    // funct3 to op for the forms shared by OP and OP_IMM
    function automatic alu_op_e base_op(input funct3_e f3);
        case (f3)
            f3_add_sub: return alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return alu_srl;
            f3_or:      return alu_or;
            f3_and:     return alu_and;
            default:    return alu_illegal;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = funct3_e'(inst[14:12]);
    assign funct7 = inst[31:25];

    // ----------------------------------------
    // Immediate generation
    // ----------------------------------------
    assign imm_i = {{20{inst[31]}}, inst[31:20]};                              // ADDI, JALR
    assign imm_u = {inst[31:12], 12'b0};                                       // AUIPC
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}; // JAL

    assign is_csr_write = (opcode == opc_system) && (inst[14:12] == funct3_csrrw)
                          && (inst[31:20] == csr_accuracy_addr);

    // ----------------------------------------
    // Operation decode
    // ----------------------------------------
    always_comb
    begin
        dec_next           = '0;
        dec_next.op        = alu_illegal;             // Unless a group matches
        dec_next.opa_sel   = opa_rs1;
        dec_next.opb_sel   = opb_rs2;
        dec_next.imm       = imm_i;
        case (opcode)
            opc_op:
            begin
                if (funct7 == funct7_base)
                    dec_next.op = base_op(funct3);
                else if (funct7 == funct7_alt && funct3 == f3_add_sub)
                    dec_next.op = alu_sub;
                else if (funct7 == funct7_alt && funct3 == f3_srl_sra)
                    dec_next.op = alu_sra;
            end
            opc_op_imm:
            begin
                dec_next.opb_sel = opb_imm;
                if (funct3 == f3_sll)                  // SLLI needs clean funct7
                    dec_next.op = (funct7 == funct7_base) ? alu_sll : alu_illegal;
                else if (funct3 == f3_srl_sra)         // SRLI or SRAI
                    dec_next.op = (funct7 == funct7_base) ? alu_srl :
                                  (funct7 == funct7_alt)  ? alu_sra : alu_illegal;
                else
                    dec_next.op = base_op(funct3);
            end
            opc_jal:
            begin
                dec_next.op      = alu_link;
                dec_next.opa_sel = opa_pc;
                dec_next.opb_sel = opb_four;
                dec_next.imm     = imm_j;             // Target, unused by link
            end
            opc_jalr:
            begin
                dec_next.op      = (funct3 == f3_add_sub) ? alu_link : alu_illegal;
                dec_next.opa_sel = opa_pc;
                dec_next.opb_sel = opb_four;
            end
            opc_auipc:
            begin
                dec_next.op      = alu_add;           // Exact, see use_approx
                dec_next.opa_sel = opa_pc;
                dec_next.opb_sel = opb_imm;
                dec_next.imm     = imm_u;
            end
            default: ;                                 // Stays illegal
        endcase
        dec_next.rs1_value  = rs1_data;
        dec_next.rs2_value  = rs2_data;
        dec_next.pc         = pc;
        dec_next.rd         = inst[11:7];
        dec_next.accuracy   = accuracy;                // Value before this edge
        dec_next.use_approx = APPROX_ENABLE && (opcode == opc_op || opcode == opc_op_imm)
                              && (dec_next.op == alu_add || dec_next.op == alu_sub);
    end

    // ----------------------------------------
    // Accuracy CSR and stage registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            accuracy  <= RESET_ACCURACY;
            dec_valid <= 1'b0;
        end
        else
        begin
            if (inst_valid && is_csr_write)
                accuracy <= rs1_data[7:0];             // Low byte of rs1
            dec_valid <= inst_valid && !is_csr_write;  // CSR write is swallowed
        end
    end

    always_ff @(posedge clk)
    begin
        if (inst_valid)
            dec_op <= dec_next;                        // Payload, no reset
    end

endmodule

`default_nettype wire

// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // ----------------------------------------
    // ALU operations after decode
    // ----------------------------------------
    typedef enum logic [3:0] {
        alu_add,                                       // ADD, ADDI, AUIPC
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,                                       // Arithmetic right shift
        alu_or,
        alu_and,
        alu_link,                                      // PC+4 for JAL and JALR
        alu_illegal                                    // Undecodable word
    } alu_op_e;

    // Operand multiplexer selects
    typedef enum logic {
        opa_rs1,
        opa_pc
    } opa_sel_e;

    typedef enum logic [1:0] {
        opb_rs2,
        opb_imm,
        opb_four                                       // Constant 4 for link
    } opb_sel_e;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------
    typedef struct packed {
        alu_op_e                          op;
        opa_sel_e                         opa_sel;
        opb_sel_e                         opb_sel;
        logic [rv32_isa_pkg::xlen-1:0]    rs1_value;  // Register file operand 1
        logic [rv32_isa_pkg::xlen-1:0]    rs2_value;  // Register file operand 2
        logic [rv32_isa_pkg::xlen-1:0]    imm;        // I, U or J immediate
        logic [rv32_isa_pkg::xlen-1:0]    pc;
        logic [4:0]                       rd;
        logic                             use_approx; // Adder may go inexact
        logic [7:0]                       accuracy;   // CSR value at decode
    } decoded_op_t;

    typedef struct packed {
        logic [4:0]                       rd;
        logic [rv32_isa_pkg::xlen-1:0]    value;
        logic                             illegal;
    } exec_result_t;

endpackage

`default_nettype wire

// ==== design/rv32_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_top
    import rv32_isa_pkg::*;
    import exec_pkg::*;
#(
    parameter bit         APPROX_ENABLE  = 1'b1,      // Approximate ADD/ADDI/SUB
    parameter logic [7:0] RESET_ACCURACY = 8'd32      // Accuracy CSR reset value
)
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            inst_valid,
    input  wire logic [31:0]     inst,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] rs1_data,
    input  wire logic [xlen-1:0] rs2_data,
    output logic                 result_valid,         // Two edges after inst_valid
    output exec_result_t         result
);

    // Decode to ALU
    logic        dec_valid;
    decoded_op_t dec_op;

    decode_stage #(
        .APPROX_ENABLE  (APPROX_ENABLE),
        .RESET_ACCURACY (RESET_ACCURACY)
    ) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op)
    );

    arithmetic_logic_unit u_alu (                      // Holds the adder
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// ==== design/rv32_isa_pkg.sv ====
`default_nettype none

package rv32_isa_pkg;

    // ----------------------------------------
    // Machine width
    // ----------------------------------------
    parameter int xlen = 32;                          // RV32 data path

    // ----------------------------------------
    // Major opcodes, inst[6:0]
    // ----------------------------------------
    typedef enum logic [6:0] {
        opc_op     = 7'b01_100_11,                     // R-type ALU
        opc_op_imm = 7'b00_100_11,                     // I-type ALU
        opc_jal    = 7'b11_011_11,                     // Jump and link
        opc_jalr   = 7'b11_001_11,                     // Jump and link register
        opc_auipc  = 7'b00_101_11,                     // Add upper immediate to PC
        opc_system = 7'b11_100_11                      // CSR access lives here
    } opcode_e;

    // ----------------------------------------
    // funct3 codes of the integer ALU group
    // ----------------------------------------
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,                           // ADD, SUB, ADDI
        f3_sll     = 3'b001,                           // Shift left
        f3_slt     = 3'b010,                           // Signed compare
        f3_sltu    = 3'b011,                           // Unsigned compare
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,                           // Logical or arithmetic right
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_e;

    // funct7 variants
    parameter logic [6:0] funct7_base = 7'b000_0000;   // Plain ops and shifts
    parameter logic [6:0] funct7_alt  = 7'b010_0000;   // SUB and SRA/SRAI

    // ----------------------------------------
    // CSR access
    // ----------------------------------------
    parameter logic [2:0]  funct3_csrrw      = 3'b001;  // CSRRW under SYSTEM
    parameter logic [11:0] csr_accuracy_addr = 12'h800; // Custom accuracy CSR

endpackage

`default_nettype wire

// ==== verif/exec_trace.txt ====
# Columns in hex: inst pc rs1 rs2 expect_valid rd value illegal
# rd, value and illegal are ignored on rows with expect_valid 0
002081B3 00000100 12345678 11111111 1 03 23456789 0
40208233 00000104 00000005 00000007 1 04 FFFFFFFE 0
002092B3 00000108 0000000F 00000023 1 05 00000078 0
0020A333 0000010C FFFFFFFF 00000001 1 06 00000001 0
0020B3B3 00000110 FFFFFFFF 00000001 1 07 00000000 0
0020C433 00000114 F0F0F0F0 FF00FF00 1 08 0FF00FF0 0
0020D4B3 00000118 80000000 00000004 1 09 08000000 0
4020D533 0000011C 80000000 00000004 1 0A F8000000 0
0020E5B3 00000120 0F0F0000 000000FF 1 0B 0F0F00FF 0
0020F633 00000124 12345678 0000FFFF 1 0C 00005678 0
FFF08693 00000128 00000010 00000000 1 0D 0000000F 0
0050A713 0000012C FFFFFFF0 00000000 1 0E 00000001 0
0050B793 00000130 FFFFFFF0 00000000 1 0F 00000000 0
FFF0C813 00000134 0000FFFF 00000000 1 10 FFFF0000 0
0F00E893 00000138 00000001 00000000 1 11 000000F1 0
7FF0F913 0000013C FFFFFFFF 00000000 1 12 000007FF 0
00809993 00000140 000000AB 00000000 1 13 0000AB00 0
0080DA13 00000144 F0000000 00000000 1 14 00F00000 0
4080DA93 00000148 F0000000 00000000 1 15 FFF00000 0
000000EF 00001000 00000000 00000000 1 01 00001004 0
000100E7 00002000 12345678 00000000 1 01 00002004 0
80009073 0000014C 00000000 00000000 0 00 00000000 0
12345297 00000150 00000000 00000000 1 05 12345150 0
000000EF 00003000 00000000 00000000 1 01 00003004 0
002081B3 00000158 0F0F0F0F 01010101 1 03 0F0F0F0F 0
80009073 0000015C 00000018 00000000 0 00 00000000 0
002081B3 00000160 000000FF 00000081 1 03 000001FF 0
0C008B13 00000164 00000180 00000000 1 16 000002C0 0
40208233 00000168 00001080 00000001 1 04 000010FF 0
80009073 0000016C 00000040 00000000 0 00 00000000 0
002081B3 00000170 000000FF 00000081 1 03 00000180 0
4020C433 00000174 12345678 87654321 1 08 00000000 1
00000000 00000178 00000000 00000000 1 00 00000000 1

// ==== verif/rv32_exec_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_assertions
    import exec_pkg::*;
(
    input wire logic         clk,
    input wire logic         rst_n,
    input wire logic         inst_valid,
    input wire logic [31:0]  inst,
    input wire logic         result_valid,
    input wire exec_result_t result
);

    int   fail_count = 0;
    logic accuracy_write;                             // Swallowed by decode

    assign accuracy_write = (inst[6:0] == 7'b1110011) && (inst[14:12] == 3'b001)
                            && (inst[31:20] == 12'h800);

    // ----------------------------------------
    // Reset and latency
    // ----------------------------------------
    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
    else
    begin
        fail_count++;
        $error("result_valid high while in reset");
    end

    issue_to_result: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !accuracy_write |-> ##2 result_valid)
    else
    begin
        fail_count++;
        $error("No result_valid two cycles after issue");
    end

    result_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(inst_valid && !accuracy_write, 2))
    else
    begin
        fail_count++;
        $error("result_valid without an issue two cycles before");
    end

    // ----------------------------------------
    // Result payload
    // ----------------------------------------
    illegal_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result.illegal |-> result.value == '0)
    else
    begin
        fail_count++;
        $error("Illegal result carries a nonzero value");
    end

    result_known: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> !$isunknown(result))
    else
    begin
        fail_count++;
        $error("Unknown bits on result while valid");
    end

endmodule

bind rv32_exec_top rv32_exec_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .result_valid (result_valid),
    .result       (result)
);

`default_nettype wire

// ==== verif/tb_rv32_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_exec
    import exec_pkg::*;
();

    localparam string trace_path   = "verif/exec_trace.txt";
    localparam int    random_count = 40;             // Random ADD and CSRRW words

    typedef struct packed {
        logic [31:0]  inst;
        logic [31:0]  pc;
        logic [31:0]  rs1;
        logic [31:0]  rs2;
        logic         expect_valid;                  // Low for accuracy writes
        exec_result_t expected;
    } trace_entry_t;

    logic         clk;
    logic         rst_n;
    logic         inst_valid;
    logic [31:0]  inst;
    logic [31:0]  pc;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    logic         result_valid;
    exec_result_t result;

    trace_entry_t trace_q[$];
    exec_result_t expected_q[$];                     // In issue order
    logic [1:0]   valid_pipe;                        // Issue history for result_valid
    logic         drive_expect;
    logic         monitor_on;
    logic [31:0]  lfsr_state;
    int           value_errors;
    int           flow_errors;
    int           cycle_count  = 0;
    int           cycle_limit  = 1000;

    rv32_exec_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result_valid (result_valid),
        .result       (result)
    );

    always #50 clk = ~clk;                            // 100 ns period

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits       = {bits[30:0], lfsr_state[0]}; // One step per bit
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // Lower L bits are a|b, guessed carry from bit L-1, exact upper part
    function automatic logic [31:0] approx_model(input logic [31:0] a, input logic [31:0] b,
                                                 input logic [7:0] acc);
        int          len;
        logic [31:0] low_part;
        logic [31:0] upper;
        logic        carry;
        len = (acc >= 8'd32) ? 0 : 32 - int'(acc);
        if (len == 0)
            return a + b;
        if (len == 32)
            return a | b;                             // Carry falls off the top
        low_part = '0;
        for (int i = 0; i < len; i++)
            low_part[i] = a[i] | b[i];
        carry = a[len-1] & b[len-1];
        upper = (a >> len) + (b >> len) + {31'b0, carry};
        return (upper << len) | low_part;
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_valid(input bit actual, input bit expected);
        if (actual != expected)
        begin
            flow_errors++;
            if (expected)
                $display("Missing result at %0t ns, result_valid low two cycles after issue",
                         $time);
            else
                $display("Spurious result_valid at %0t ns with no instruction due", $time);
        end
    endtask

    task automatic check_result(input exec_result_t actual, input exec_result_t expected);
        if (actual !== expected)
        begin
            value_errors++;
            $display({"[FAIL] %0t ns: got rd=%0d value=%h illegal=%b,",
                      " expected rd=%0d value=%h illegal=%b"},
                     $time, actual.rd, actual.value, actual.illegal,
                     expected.rd, expected.value, expected.illegal);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic load_trace();
        int           fd;
        string        line;
        logic [31:0]  f_inst;
        logic [31:0]  f_pc;
        logic [31:0]  f_rs1;
        logic [31:0]  f_rs2;
        logic [31:0]  f_valid;
        logic [31:0]  f_rd;
        logic [31:0]  f_value;
        logic [31:0]  f_illegal;
        trace_entry_t entry;
        fd = $fopen(trace_path, "r");
        if (fd == 0)
        begin
            flow_errors++;
            $display("Cannot open trace file %s", trace_path);
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_inst, f_pc, f_rs1, f_rs2,
                        f_valid, f_rd, f_value, f_illegal) == 8)  // Column header fails the scan
            begin
                entry.inst             = f_inst;
                entry.pc               = f_pc;
                entry.rs1              = f_rs1;
                entry.rs2              = f_rs2;
                entry.expect_valid     = f_valid[0];
                entry.expected.rd      = f_rd[4:0];
                entry.expected.value   = f_value;
                entry.expected.illegal = f_illegal[0];
                trace_q.push_back(entry);
            end
        end
        $fclose(fd);
        if (trace_q.size() == 0)
        begin
            flow_errors++;
            $display("Trace file %s holds no instructions", trace_path);
        end
    endtask

    task automatic drive_inst(input logic [31:0] w, input logic [31:0] w_pc,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic exp_valid, input exec_result_t exp_res);
        @(posedge clk);
        #1;
        inst_valid   = 1'b1;
        inst         = w;
        pc           = w_pc;
        rs1_data     = a;
        rs2_data     = b;
        drive_expect = exp_valid;
        if (exp_valid)
            expected_q.push_back(exp_res);
    endtask

    task automatic run_random();
        logic [31:0]  sel;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  acc_bits;
        logic [31:0]  rd_bits;
        logic [31:0]  pc_r;
        logic [7:0]   acc;
        exec_result_t exp_res;
        pc_r = 32'h0000_0400;
        acc  = 8'd32;
        for (int n = 0; n < random_count; n++)
        begin
            take_bits(2, sel);
            if (n == 0 || sel[1:0] == 2'b00)          // CSRRW x0, 0x800, x1
            begin
                take_bits(6, acc_bits);
                acc = {2'b00, acc_bits[5:0]};         // Spans both sides of 32
                drive_inst({12'h800, 5'd1, 3'b001, 5'd0, 7'b1110011}, pc_r,
                           {26'h0, acc_bits[5:0]}, 32'h0, 1'b0, '0);
            end
            else
            begin
                take_bits(5, rd_bits);
                take_bits(32, a);
                take_bits(32, b);
                exp_res.rd      = rd_bits[4:0];
                exp_res.value   = approx_model(a, b, acc);
                exp_res.illegal = 1'b0;
                drive_inst({7'b0, 5'd2, 5'd1, 3'b000, rd_bits[4:0], 7'b0110011}, pc_r,
                           a, b, 1'b1, exp_res);
            end
            pc_r = pc_r + 32'd4;
        end
    endtask

    // ----------------------------------------
    // Monitor and timeout
    // ----------------------------------------
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[0], inst_valid && drive_expect};
    end

    always @(negedge clk)                             // Outputs settled mid-cycle
    begin
        exec_result_t exp_entry;
        if (monitor_on)
        begin
            check_valid(result_valid, valid_pipe[1]);
            if (result_valid && valid_pipe[1])
            begin
                if (expected_q.size() == 0)
                begin
                    flow_errors++;
                    $display("Result at %0t ns with no expected entry left", $time);
                end
                else
                begin
                    exp_entry = expected_q.pop_front();
                    check_result(result, exp_entry);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, results still outstanding", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        drive_expect = 1'b0;
        monitor_on   = 1'b0;
        value_errors = 0;
        flow_errors  = 0;
        lfsr_state   = 32'h7605c9ab;
        load_trace();
        cycle_limit = (trace_q.size() + random_count) * 2 + 50;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_valid(result_valid, 1'b0);              // Reset state
        check_result(result, '0);
        monitor_on = 1'b1;
        foreach (trace_q[i])
            drive_inst(trace_q[i].inst, trace_q[i].pc, trace_q[i].rs1, trace_q[i].rs2,
                       trace_q[i].expect_valid, trace_q[i].expected);
        run_random();
        @(posedge clk);
        #1;
        inst_valid   = 1'b0;
        drive_expect = 1'b0;
        while (expected_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);                    // Watch for stray strobes
        $display("Errors: %0d value, %0d flow, %0d assertion", value_errors, flow_errors,
                 uut.u_assertions.fail_count);
        if (value_errors == 0 && flow_errors == 0 && uut.u_assertions.fail_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
